//--- all.f
source/l2_cache_pkg.sv
source/l2_arb_stage.sv
source/l2_tag_stage.sv
source/l2_read_stage.sv
source/l2_update_stage.sv
source/l2_mem_interface.sv
source/l2_cache.sv
test/l2_cache_checker.sv
test/l2_cache_tb.sv

//--- Makefile
TOP = l2_cache_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

//--- test/l2_cache_tb.sv
module l2_cache_tb import l2_cache_pkg::*; ();
    localparam int clk_period = 20;
    localparam int reqs_per_core = 300;
    localparam int window_words = 256;                             // 64 lines over 16 sets
    localparam l2_word_t fill_mult = 32'h9e37_79b1;

    logic clk;
    logic rst_n;
    logic [num_cores-1:0] request_valid;
    l2_req_t request[num_cores];
    logic ready[num_cores];
    logic response_valid;
    l2_rsp_t response;
    logic mem_read_en;
    l2_line_addr_t mem_read_addr;
    logic mem_read_valid;
    l2_line_t mem_read_data;
    logic mem_write_en;
    l2_line_addr_t mem_write_addr;
    l2_line_t mem_write_data;
    logic [l2_cache_pkg::perf_events-1:0] perf_events;
    logic drain_done;
    int responses_seen;
    logic error_seen;
    l2_line_t mem_model[1 << line_addr_bits];                      // System memory
    l2_line_addr_t read_addr;
    int read_delay;                                                // Cycles left on the open read

    l2_cache u_dut(.*);
    l2_cache_checker #(.fill_mult(fill_mult)) u_checker(.*);

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Drives one core and holds each request until ready
    task automatic drive_core(input int core);
        l2_req_t req;
        for (int n = 0; n < reqs_per_core; n++) begin
            if ($urandom % 4 == 0) begin                           // Occasional idle cycle
                request_valid[core] <= 1'b0;
                @(posedge clk);
            end
            req.op = ($urandom % 2 == 0) ? op_load : op_store;
            req.core_id = l2_core_id_t'(core);
            req.addr = l2_addr_t'($urandom % window_words);
            req.data = $urandom;
            request_valid[core] <= 1'b1;
            request[core] <= req;
            @(posedge clk);
            while (!ready[core])
                @(posedge clk);
        end
        request_valid[core] <= 1'b0;
    endtask

    initial begin
        void'($urandom(83));
        rst_n = 1'b0;
        request_valid = '0;
        drain_done = 1'b0;
        for (int i = 0; i < num_cores; i++)
            request[i] = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);                                 // Idle cycles after reset
        fork
            drive_core(0);
            drive_core(1);
        join
        while (responses_seen < num_cores * reqs_per_core)
            @(posedge clk);
        drain_done <= 1'b1;                                        // Checker runs end checks
        @(posedge clk);
        @(posedge clk);
        if (!error_seen) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            $display("*** TEST FAILED ***");
            $fatal(1, "Checker reported an error at the end of the run");
        end
    end

    // Memory model answering reads after 2 to 8 cycles
    initial begin
        mem_read_valid = 1'b0;
        mem_read_data = '0;
        read_addr = '0;
        read_delay = 0;
        for (int a = 0; a < (1 << line_addr_bits); a++)
            for (int w = 0; w < words_per_line; w++)
                mem_model[a][w*word_bits +: word_bits] =
                    l2_word_t'(a * words_per_line + w) * fill_mult;
        forever begin
            @(posedge clk);
            mem_read_valid <= 1'b0;
            if (mem_write_en)
                mem_model[mem_write_addr] <= mem_write_data;
            if (mem_read_en) begin
                read_addr <= mem_read_addr;
                read_delay <= 2 + $urandom % 7;
            end else if (read_delay == 1) begin
                mem_read_valid <= 1'b1;
                mem_read_data <= mem_model[read_addr];
                read_delay <= 0;
            end else if (read_delay > 1) begin
                read_delay <= read_delay - 1;
            end
        end
    end

    initial begin
        @(posedge error_seen);
        $display("*** TEST FAILED ***");
        $fatal(1, "Checker stopped the run at its first error");
    end

    // 40 cycles per request covers the slowest miss chains
    initial begin
        #(num_cores * reqs_per_core * 40 * clk_period);
        $display("*** TEST FAILED ***");
        $fatal(1, "Timeout before all responses arrived");
    end
endmodule

//--- test/l2_cache_checker.sv
module l2_cache_checker import l2_cache_pkg::*; #(
    parameter l2_word_t fill_mult = 32'h0000_0001                  // Memory word = address * fill_mult
) (
    input logic clk,
    input logic rst_n,
    input logic [num_cores-1:0] request_valid,
    input l2_req_t request[num_cores],
    input logic ready[num_cores],
    input logic response_valid,
    input l2_rsp_t response,
    input logic mem_read_en,
    input l2_line_addr_t mem_read_addr,
    input logic mem_read_valid,
    input l2_line_t mem_read_data,
    input logic mem_write_en,
    input l2_line_addr_t mem_write_addr,
    input l2_line_t mem_write_data,
    input logic [l2_cache_pkg::perf_events-1:0] perf_events,
    input logic drain_done,
    output int responses_seen,
    output logic error_seen
);
    l2_word_t shadow[1 << $bits(l2_addr_t)];                       // Architectural memory per word
    l2_req_t pending[$];                                           // Transferred and not yet answered
    logic first_request_seen;
    logic read_busy;                                               // Memory read still unanswered
    int hit_count;
    int miss_count;

    task automatic report_mismatch(input string msg);
        $display("Mismatch at time %0t: %s", $time, msg);
        error_seen = 1'b1;
    endtask

    task automatic report_violation(input string msg);
        $display("Error at time %0t: %s", $time, msg);
        error_seen = 1'b1;
    endtask

    function automatic l2_line_t shadow_line(input l2_line_addr_t line_addr);
        l2_line_t line;
        for (int w = 0; w < words_per_line; w++)
            line[w*word_bits +: word_bits] = shadow[{line_addr, l2_offset_t'(w)}];
        return line;
    endfunction

    // Some outstanding request waits on this line
    function automatic logic line_pending(input l2_line_addr_t line_addr);
        for (int k = 0; k < pending.size(); k++)
            if ({pending[k].addr.tag, pending[k].addr.set} == line_addr)
                return 1'b1;
        return 1'b0;
    endfunction

    // Match core, op and address and prefer the store whose data came back
    function automatic int find_pending(input l2_rsp_t rsp);
        int fallback;
        fallback = -1;
        for (int k = 0; k < pending.size(); k++) begin
            if (pending[k].core_id == rsp.core_id && pending[k].op == rsp.op
                    && pending[k].addr == rsp.addr) begin
                if (rsp.op == op_load
                        || pending[k].data == rsp.line[rsp.addr.offset*word_bits +: word_bits])
                    return k;
                if (fallback < 0)
                    fallback = k;
            end
        end
        return fallback;
    endfunction

    always @(posedge clk or negedge rst_n) begin
        int idx;
        l2_line_t expected;
        if (!rst_n) begin
            for (int a = 0; a < $size(shadow); a++)
                shadow[a] = l2_word_t'(a) * fill_mult;             // Same start as memory model
            pending.delete();
            first_request_seen = 1'b0;
            read_busy = 1'b0;
            hit_count = 0;
            miss_count = 0;
            responses_seen = 0;
            error_seen = 1'b0;
        end else begin
            if (!first_request_seen)                               // Quiet until first transfer
                assert (!response_valid && !mem_read_en && !mem_write_en && perf_events == '0)
                    else report_violation("Control output active before the first request");
            assert (!(ready[0] && ready[1]))
                else report_violation("Ready high for both cores in one cycle");
            for (int i = 0; i < num_cores; i++) begin
                assert (!ready[i] || request_valid[i])
                    else report_violation($sformatf("Ready high for idle core %0d", i));
                if (request_valid[i] && ready[i]) begin
                    pending.push_back(request[i]);
                    first_request_seen = 1'b1;
                end
            end
            if (mem_read_valid)
                read_busy = 1'b0;
            if (mem_read_en) begin
                assert (!read_busy)
                    else report_violation("Memory read issued while another was unanswered");
                assert (line_pending(mem_read_addr))
                    else report_violation($sformatf("Memory read of line %0h that no request waits for",
                                                    mem_read_addr));
                read_busy = 1'b1;
            end
            assert (perf_events[0] == mem_write_en)
                else report_mismatch($sformatf("writeback pulse %0b, write strobe %0b",
                                               perf_events[0], mem_write_en));
            if (mem_write_en)                                      // Writeback must hold every store
                assert (mem_write_data == shadow_line(mem_write_addr))
                    else report_mismatch($sformatf("line %0h written as %h, expected %h",
                        mem_write_addr, mem_write_data, shadow_line(mem_write_addr)));
            if (perf_events[2])
                hit_count++;
            if (perf_events[1])
                miss_count++;
            if (response_valid) begin
                idx = find_pending(response);
                assert (idx >= 0)
                    else report_violation($sformatf("Response for core %0d addr %0h unrequested",
                                                    response.core_id, response.addr));
                if (idx >= 0) begin
                    expected = shadow_line({response.addr.tag, response.addr.set});
                    if (response.op == op_store)                   // Own word already applied
                        expected[response.addr.offset*word_bits +: word_bits] = pending[idx].data;
                    assert (response.line == expected)
                        else report_mismatch($sformatf("addr %0h line %h, expected %h",
                                                       response.addr, response.line, expected));
                    if (response.op == op_store)
                        shadow[response.addr] = pending[idx].data;
                    pending.delete(idx);
                    responses_seen++;
                end
            end
            if (drain_done) begin
                assert (pending.size() == 0)
                    else report_violation($sformatf("%0d requests never answered",
                                                    pending.size()));
                assert (hit_count + miss_count == responses_seen)
                    else report_mismatch($sformatf("hits %0d plus misses %0d, responses %0d",
                                                   hit_count, miss_count, responses_seen));
            end
        end
    end
endmodule

//--- source/l2_cache.sv
module l2_cache import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic [num_cores-1:0] request_valid,
    input l2_req_t request[num_cores],
    output logic ready[num_cores],
    output logic response_valid,
    output l2_rsp_t response,
    output logic mem_read_en,
    output l2_line_addr_t mem_read_addr,
    input logic mem_read_valid,
    input l2_line_t mem_read_data,
    output logic mem_write_en,
    output l2_line_addr_t mem_write_addr,
    output l2_line_t mem_write_data,
    output logic [l2_cache_pkg::perf_events-1:0] perf_events
);
    logic arb_valid;                                               // Arbitrate to tag
    l2_pipe_t arb_pipe;
    logic tag_valid;                                               // Tag to read
    l2_pipe_t tag_pipe;
    logic line_valid;
    logic line_dirty;
    l2_tag_t line_tag;
    logic read_valid;                                              // Read to update
    l2_pipe_t read_pipe;
    l2_line_t read_line;
    logic hit;
    logic tag_update_en;                                           // Read back to tag
    l2_set_t tag_update_set;
    l2_tag_t tag_update_tag;
    logic tag_update_dirty;
    logic data_write_en;                                           // Update back to read
    l2_set_t data_write_set;
    l2_line_t data_write_line;
    logic miss_push;
    l2_req_t miss_req;
    logic wb_push;
    l2_wb_t wb_entry;
    logic restart_valid;
    l2_pipe_t restart;
    logic stall;
    logic perf_hit;
    logic perf_miss;
    logic perf_writeback;

    l2_arb_stage u_arb_stage(.*);
    l2_tag_stage u_tag_stage(.*);
    l2_read_stage u_read_stage(.*);
    l2_update_stage u_update_stage(.*);
    l2_mem_interface u_mem_interface(.*);

    assign perf_events = {perf_hit, perf_miss, perf_writeback};
endmodule

//--- source/l2_mem_interface.sv
module l2_mem_interface import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic miss_push,
    input l2_req_t miss_req,
    input logic wb_push,
    input l2_wb_t wb_entry,
    output logic mem_read_en,
    output l2_line_addr_t mem_read_addr,
    output logic mem_write_en,
    output l2_line_addr_t mem_write_addr,
    output l2_line_t mem_write_data,
    input logic mem_read_valid,
    input l2_line_t mem_read_data,
    output logic restart_valid,
    output l2_pipe_t restart,
    output logic stall,
    output logic perf_writeback
);
    localparam int ptr_bits = $clog2(miss_queue_depth);

    typedef enum logic [2:0] {
        s_idle,
        s_writeback,
        s_read,
        s_wait,
        s_restart,
        s_drain0,                                                  // Fill on its way to read stage
        s_drain1
    } seq_state_t;

    seq_state_t state;
    l2_req_t miss_fifo[miss_queue_depth];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0] count;
    logic pop;
    l2_req_t head;
    logic wb_pending;
    l2_wb_t wb_reg;
    l2_line_t fill_line;

    assign head = miss_fifo[rd_ptr];
    assign pop = state == s_restart;
    assign stall = count >= 2;

    assign mem_read_en = state == s_read;
    assign mem_read_addr = {head.addr.tag, head.addr.set};
    assign mem_write_en = state == s_writeback;
    assign mem_write_addr = wb_reg.line_addr;
    assign mem_write_data = wb_reg.line;
    assign perf_writeback = mem_write_en;
    assign restart_valid = state == s_restart;
    assign restart = '{req: head, is_fill: 1'b1, fill_line: fill_line};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            wb_pending <= 1'b0;
        end else begin
            if (miss_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count <= count + (ptr_bits + 1)'(miss_push) - (ptr_bits + 1)'(pop);
            if (wb_push)
                wb_pending <= 1'b1;
            else if (state == s_writeback)
                wb_pending <= 1'b0;
            case (state)
                s_idle: begin
                    if (wb_pending)                                // Victim goes before next read
                        state <= s_writeback;
                    else if (count != 0)
                        state <= s_read;
                end
                s_writeback: state <= s_idle;
                s_read: state <= s_wait;
                s_wait: if (mem_read_valid) state <= s_restart;
                s_restart: state <= s_drain0;
                s_drain0: state <= s_drain1;
                s_drain1: state <= s_idle;                         // Any victim now in wb_reg
                default: state <= s_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (miss_push)
            miss_fifo[wr_ptr] <= miss_req;
        if (wb_push)
            wb_reg <= wb_entry;
        if (state == s_wait && mem_read_valid)
            fill_line <= mem_read_data;
    end
endmodule

//--- source/l2_update_stage.sv
module l2_update_stage import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic read_valid,
    input l2_pipe_t read_pipe,
    input l2_line_t read_line,
    input logic hit,
    output logic data_write_en,
    output l2_set_t data_write_set,
    output l2_line_t data_write_line,
    output logic response_valid,
    output l2_rsp_t response,
    output logic perf_hit
);
    l2_line_t base_line;
    l2_line_t merged_line;
    logic is_store;

    assign is_store = read_pipe.req.op == op_store;

    // Collided fill keeps the cached copy, memory data is stale
    assign base_line = (read_pipe.is_fill && !hit) ? read_pipe.fill_line : read_line;

    always_comb begin
        merged_line = base_line;
        if (is_store)
            merged_line[read_pipe.req.addr.offset * word_bits +: word_bits] = read_pipe.req.data;
    end

    assign data_write_en = read_valid && (read_pipe.is_fill || is_store);
    assign data_write_set = read_pipe.req.addr.set;
    assign data_write_line = merged_line;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            response_valid <= 1'b0;
            perf_hit <= 1'b0;
        end else begin
            response_valid <= read_valid;
            perf_hit <= read_valid && hit && !read_pipe.is_fill;  // Fills already counted as miss
        end
    end

    always_ff @(posedge clk) begin
        response <= '{op: read_pipe.req.op, core_id: read_pipe.req.core_id,
                      addr: read_pipe.req.addr, line: merged_line};
    end
endmodule

//--- source/l2_read_stage.sv
module l2_read_stage import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic tag_valid,
    input l2_pipe_t tag_pipe,
    input logic line_valid,
    input logic line_dirty,
    input l2_tag_t line_tag,
    input logic data_write_en,
    input l2_set_t data_write_set,
    input l2_line_t data_write_line,
    output logic read_valid,
    output l2_pipe_t read_pipe,
    output l2_line_t read_line,
    output logic hit,
    output logic tag_update_en,
    output l2_set_t tag_update_set,
    output l2_tag_t tag_update_tag,
    output logic tag_update_dirty,
    output logic miss_push,
    output l2_req_t miss_req,
    output logic wb_push,
    output l2_wb_t wb_entry,
    output logic perf_miss
);
    l2_line_t data_array[num_sets];
    l2_set_t set_idx;
    l2_line_t array_line;
    logic cache_hit;
    logic is_store;
    logic fill_miss;                                               // Fill that installs its line
    logic core_miss;

    assign set_idx = tag_pipe.req.addr.set;
    assign is_store = tag_pipe.req.op == op_store;
    assign cache_hit = line_valid && line_tag == tag_pipe.req.addr.tag;
    assign fill_miss = tag_valid && tag_pipe.is_fill && !cache_hit;
    assign core_miss = tag_valid && !tag_pipe.is_fill && !cache_hit;

    // Update stage writes the same set at this edge
    assign array_line = (data_write_en && data_write_set == set_idx) ? data_write_line
                                                                     : data_array[set_idx];

    always_ff @(posedge clk) begin
        if (data_write_en)
            data_array[data_write_set] <= data_write_line;
    end

    // Install on fill, mark dirty on store hit; collided fill store counts as a hit
    assign tag_update_en = fill_miss || (tag_valid && cache_hit && is_store);
    assign tag_update_set = set_idx;
    assign tag_update_tag = tag_pipe.req.addr.tag;
    assign tag_update_dirty = is_store;

    assign miss_push = core_miss;
    assign miss_req = tag_pipe.req;
    assign perf_miss = core_miss;

    // Victim leaves before the new line overwrites it
    assign wb_push = fill_miss && line_valid && line_dirty;
    assign wb_entry = '{line_addr: {line_tag, set_idx}, line: array_line};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            read_valid <= 1'b0;
        else
            read_valid <= tag_valid && (cache_hit || tag_pipe.is_fill);  // Misses drop out
    end

    always_ff @(posedge clk) begin
        read_pipe <= tag_pipe;
        read_line <= array_line;
        hit <= cache_hit;
    end
endmodule

//--- source/l2_tag_stage.sv
module l2_tag_stage import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic arb_valid,
    input l2_pipe_t arb_pipe,
    input logic tag_update_en,
    input l2_set_t tag_update_set,
    input l2_tag_t tag_update_tag,
    input logic tag_update_dirty,
    output logic tag_valid,
    output l2_pipe_t tag_pipe,
    output logic line_valid,
    output logic line_dirty,
    output l2_tag_t line_tag
);
    logic [num_sets-1:0] valid_bits;
    logic [num_sets-1:0] dirty_bits;
    l2_tag_t tag_array[num_sets];
    l2_set_t lookup_set;
    logic bypass;
    logic lookup_valid;
    logic lookup_dirty;
    l2_tag_t lookup_tag;

    assign lookup_set = arb_pipe.req.addr.set;

    // Update from read stage lands at this edge, so take it directly
    assign bypass = tag_update_en && tag_update_set == lookup_set;
    assign lookup_valid = bypass ? 1'b1 : valid_bits[lookup_set];   // Update always installs
    assign lookup_dirty = bypass ? tag_update_dirty : dirty_bits[lookup_set];
    assign lookup_tag = bypass ? tag_update_tag : tag_array[lookup_set];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_bits <= '0;                                      // All invalid and clean
            dirty_bits <= '0;
        end else if (tag_update_en) begin
            valid_bits[tag_update_set] <= 1'b1;
            dirty_bits[tag_update_set] <= tag_update_dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (tag_update_en)
            tag_array[tag_update_set] <= tag_update_tag;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            tag_valid <= 1'b0;
        else
            tag_valid <= arb_valid;
    end

    // Lookup result travels with its request
    always_ff @(posedge clk) begin
        tag_pipe <= arb_pipe;
        line_valid <= lookup_valid;
        line_dirty <= lookup_dirty;
        line_tag <= lookup_tag;
    end
endmodule

//--- source/l2_arb_stage.sv
module l2_arb_stage import l2_cache_pkg::*; (
    input logic clk,
    input logic rst_n,
    input logic [num_cores-1:0] request_valid,
    input l2_req_t request[num_cores],
    output logic ready[num_cores],
    input logic restart_valid,
    input l2_pipe_t restart,
    input logic stall,
    output logic arb_valid,
    output l2_pipe_t arb_pipe
);
    logic [core_id_bits-1:0] rr_ptr;                               // Core with first claim
    logic [core_id_bits-1:0] grant_id;
    logic grant_any;
    logic can_grant;

    assign can_grant = !restart_valid && !stall;                   // Restart always wins

    // Round robin search starting at rr_ptr
    always_comb begin
        int idx;
        grant_any = 1'b0;
        grant_id = rr_ptr;
        for (int k = 0; k < num_cores; k++) begin
            idx = (int'(rr_ptr) + k) % num_cores;
            if (!grant_any && can_grant && request_valid[idx]) begin
                grant_any = 1'b1;
                grant_id = core_id_bits'(idx);
            end
        end
    end

    always_comb begin
        for (int i = 0; i < num_cores; i++)
            ready[i] = grant_any && grant_id == core_id_bits'(i);  // One hot grant
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arb_valid <= 1'b0;
            rr_ptr <= '0;
        end else begin
            arb_valid <= restart_valid || grant_any;
            if (grant_any)                                         // Move past the winner
                rr_ptr <= (grant_id == core_id_bits'(num_cores - 1)) ? '0 : grant_id + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (restart_valid)
            arb_pipe <= restart;
        else
            arb_pipe <= '{req: request[grant_id], is_fill: 1'b0, fill_line: '0};
    end
endmodule

//--- source/l2_cache_pkg.sv
package l2_cache_pkg;
    localparam int num_cores = 2;
    localparam int core_id_bits = 1;
    localparam int word_bits = 32;
    localparam int words_per_line = 4;
    localparam int num_sets = 16;                                  // Direct mapped, one way
    localparam int tag_bits = 6;
    localparam int set_bits = $clog2(num_sets);
    localparam int offset_bits = $clog2(words_per_line);
    localparam int line_addr_bits = tag_bits + set_bits;           // Memory side line address
    localparam int miss_queue_depth = 4;
    localparam int perf_events = 3;                                // {hit, miss, writeback}

    typedef logic [word_bits-1:0] l2_word_t;
    typedef logic [tag_bits-1:0] l2_tag_t;
    typedef logic [set_bits-1:0] l2_set_t;
    typedef logic [offset_bits-1:0] l2_offset_t;
    typedef logic [words_per_line*word_bits-1:0] l2_line_t;        // Word 0 in low bits
    typedef logic [line_addr_bits-1:0] l2_line_addr_t;
    typedef logic [core_id_bits-1:0] l2_core_id_t;

    typedef enum logic {
        op_load,
        op_store
    } l2_op_t;

    // 12 bit word address
    typedef struct packed {
        l2_tag_t tag;
        l2_set_t set;
        l2_offset_t offset;
    } l2_addr_t;

    typedef struct packed {
        l2_op_t op;
        l2_core_id_t core_id;
        l2_addr_t addr;
        l2_word_t data;                                            // Store data, unused on load
    } l2_req_t;

    typedef struct packed {
        l2_op_t op;
        l2_core_id_t core_id;
        l2_addr_t addr;
        l2_line_t line;                                            // Line after store applied
    } l2_rsp_t;

    // Carried between pipeline stages
    typedef struct packed {
        l2_req_t req;
        logic is_fill;                                             // Restarted with memory data
        l2_line_t fill_line;
    } l2_pipe_t;

    typedef struct packed {
        l2_line_addr_t line_addr;
        l2_line_t line;
    } l2_wb_t;
endpackage
